//--- Bender.yml
package:
  name: mram_tx

sources:
  - hdl/mram_tx_pkg.sv
  - hdl/mram_tx_ctrl.sv
  - hdl/mram_tx_pack.sv
  - hdl/mram_tx_erase.sv
  - hdl/mram_tx_top.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_mram_tx.sv

//--- hdl/mram_tx_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module mram_tx_ctrl
#(
   parameter int TRANS_SIZE = 16
)
(
   input  logic                                  clk,
   input  logic                                  rst_n,

   input  logic                                  push_cmd_req_i,
   output logic                                  push_cmd_gnt_o,
   input  logic [7:0]                            mram_mode_i,
   input  logic [mram_tx_pkg::ADDR_W-1:0]        data_tx_addr_i,
   input  logic [TRANS_SIZE-1:0]                 data_tx_size_i,
   input  logic [mram_tx_pkg::ADDR_W-1:0]        erase_addr_i,
   input  logic [mram_tx_pkg::ERASE_SIZE_W-1:0]  erase_size_i,
   output logic                                  pending_o,

   output logic                                  pack_start_o,
   output logic [mram_tx_pkg::ADDR_W-1:0]        pack_addr_o,
   output logic [TRANS_SIZE-1:0]                 pack_size_o,
   output logic                                  erase_start_o,
   output mram_tx_pkg::mram_mode_t               erase_mode_o,
   output logic [mram_tx_pkg::ADDR_W-1:0]        erase_addr_o,
   output logic [mram_tx_pkg::ERASE_SIZE_W-1:0]  erase_size_o,

   input  logic                                  pack_busy_i,
   input  logic                                  pack_req_i,
   input  logic [mram_tx_pkg::ADDR_W-1:0]        pack_addr_i,
   input  logic [mram_tx_pkg::BUS_W-1:0]         pack_wdata_i,
   input  logic                                  pack_eot_i,
   output logic                                  pack_gnt_o,

   input  logic                                  erase_busy_i,
   input  logic                                  erase_req_i,
   input  logic [mram_tx_pkg::ADDR_W-1:0]        erase_addr_q_i,
   input  logic [mram_tx_pkg::BUS_W-1:0]         erase_wdata_i,
   input  logic                                  erase_eot_i,
   output logic                                  erase_gnt_o,

   output logic                                  data_tx_req_o,
   output logic [mram_tx_pkg::ADDR_W-1:0]        data_tx_addr_o,
   output logic [mram_tx_pkg::BUS_W-1:0]         data_tx_wdata_o,
   output logic                                  data_tx_eot_o,
   input  logic                                  data_tx_gnt_i
);

   logic cmd_gnt;
   logic is_erase;

   assign cmd_gnt        = push_cmd_req_i && !pack_busy_i && !erase_busy_i;
   assign push_cmd_gnt_o = cmd_gnt;
   assign pending_o      = push_cmd_req_i || pack_busy_i || erase_busy_i;

   assign is_erase = (mram_mode_i == mram_tx_pkg::MODE_ERASE_CHIP) ||
                     (mram_mode_i == mram_tx_pkg::MODE_ERASE_SECT) ||
                     (mram_mode_i == mram_tx_pkg::MODE_ERASE_WORD);

   // Other codes are granted and dropped
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         pack_start_o  <= 1'b0;
         erase_start_o <= 1'b0;
      end
      else
      begin
         pack_start_o  <= cmd_gnt && (mram_mode_i == mram_tx_pkg::MODE_NORMAL_TX);
         erase_start_o <= cmd_gnt && is_erase;
      end
   end

   always_ff @(posedge clk)
   begin
      if (cmd_gnt)
      begin
         pack_addr_o  <= data_tx_addr_i;
         pack_size_o  <= data_tx_size_i;
         erase_addr_o <= erase_addr_i;
         erase_size_o <= erase_size_i;
         erase_mode_o <= mram_tx_pkg::mram_mode_t'(mram_mode_i);
      end
   end

   assign pack_gnt_o  = data_tx_gnt_i && pack_busy_i;
   assign erase_gnt_o = data_tx_gnt_i && erase_busy_i;

   always_comb
   begin
      if (pack_busy_i)
      begin
         data_tx_req_o   = pack_req_i;
         data_tx_addr_o  = pack_addr_i;
         data_tx_wdata_o = pack_wdata_i;
         data_tx_eot_o   = pack_eot_i;
      end
      else
      begin
         data_tx_req_o   = erase_req_i;
         data_tx_addr_o  = erase_addr_q_i;
         data_tx_wdata_o = erase_wdata_i;
         data_tx_eot_o   = erase_eot_i;
      end
   end

   a_one_engine: assert property (@(posedge clk) disable iff (!rst_n)
      !(pack_busy_i && erase_busy_i));

endmodule

`default_nettype wire

//--- hdl/mram_tx_erase.sv
`timescale 1ns/1ps
`default_nettype none

module mram_tx_erase
(
   input  logic                                  clk,
   input  logic                                  rst_n,

   input  logic                                  start_i,
   input  mram_tx_pkg::mram_mode_t               mode_i,
   input  logic [mram_tx_pkg::ADDR_W-1:0]        addr_i,
   input  logic [mram_tx_pkg::ERASE_SIZE_W-1:0]  size_i,

   output logic                                  busy_o,
   output logic                                  req_o,
   output logic [mram_tx_pkg::ADDR_W-1:0]        addr_o,
   output logic [mram_tx_pkg::BUS_W-1:0]         wdata_o,
   output logic                                  eot_o,
   input  logic                                  gnt_i,

   output logic                                  erase_pending_o,
   output logic                                  erase_done_o
);

   localparam logic [1:0] ST_IDLE = 2'd0;
   localparam logic [1:0] ST_REQ  = 2'd1;
   localparam logic [1:0] ST_DONE = 2'd2;

   logic [1:0]                            state_q;
   logic [mram_tx_pkg::ADDR_W-1:0]        addr_q;
   logic [mram_tx_pkg::ERASE_SIZE_W-1:0]  cnt_q;       // Requests left after this one
   logic                                  word_step_q;
   logic                                  last;

   assign last = (cnt_q == '0);

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state_q     <= ST_IDLE;
         addr_q      <= '0;
         cnt_q       <= '0;
         word_step_q <= 1'b0;
      end
      else
      begin
         case (state_q)
            ST_IDLE:
            begin
               if (start_i)
               begin
                  addr_q      <= addr_i;
                  cnt_q       <= (mode_i == mram_tx_pkg::MODE_ERASE_CHIP) ? '0 : size_i;
                  word_step_q <= (mode_i == mram_tx_pkg::MODE_ERASE_WORD);
                  state_q     <= ST_REQ;
               end
            end

            ST_REQ:
            begin
               if (gnt_i)
               begin
                  if (last)
                  begin
                     state_q <= ST_DONE;
                  end
                  else
                  begin
                     cnt_q <= cnt_q - 1'b1;
                     if (word_step_q)
                        addr_q <= addr_q + 1'b1;
                     else
                        addr_q <= {addr_q[mram_tx_pkg::ADDR_W-1:8] + 1'b1, 8'h00}; // Next sector
                  end
               end
            end

            default:
            begin
               state_q <= ST_IDLE;
            end
         endcase
      end
   end

   assign req_o           = (state_q == ST_REQ);
   assign addr_o          = addr_q;
   assign wdata_o         = {{mram_tx_pkg::PAD_W{1'b1}},
                             {(mram_tx_pkg::BUS_W - mram_tx_pkg::PAD_W){1'b1}}};
   assign eot_o           = req_o && last;
   assign erase_pending_o = req_o;
   assign erase_done_o    = (state_q == ST_DONE);
   assign busy_o          = start_i || (state_q != ST_IDLE);

   // Count stays within the command's size, a wrap would exceed it
   a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
      req_o |-> cnt_q <= size_i);

endmodule

`default_nettype wire

//--- hdl/mram_tx_pack.sv
`timescale 1ns/1ps
`default_nettype none

module mram_tx_pack
#(
   parameter int TRANS_SIZE = 16
)
(
   input  logic                                  clk,
   input  logic                                  rst_n,

   input  logic                                  start_i,
   input  logic [mram_tx_pkg::ADDR_W-1:0]        addr_i,
   input  logic [TRANS_SIZE-1:0]                 size_i,

   input  logic [mram_tx_pkg::WORD_W-1:0]        data_tx_wdata_i,
   input  logic                                  data_tx_valid_i,
   output logic                                  data_tx_ready_o,

   output logic                                  busy_o,
   output logic                                  req_o,
   output logic [mram_tx_pkg::ADDR_W-1:0]        addr_o,
   output logic [mram_tx_pkg::BUS_W-1:0]         wdata_o,
   output logic                                  eot_o,
   input  logic                                  gnt_i,
   output logic                                  tx_done_o
);

   localparam logic [1:0] ST_IDLE   = 2'd0;
   localparam logic [1:0] ST_GET_LO = 2'd1;
   localparam logic [1:0] ST_GET_HI = 2'd2;
   localparam logic [1:0] ST_SEND   = 2'd3;

   logic [1:0]                            state_q;
   logic [1:0]                            state_d;
   logic [TRANS_SIZE-1:0]                 left_q;        // Words still to accept
   logic [TRANS_SIZE-1:0]                 words_ceil;
   logic [TRANS_SIZE-1:0]                 words_init;
   logic [mram_tx_pkg::ADDR_W-1:0]        addr_q;
   logic [mram_tx_pkg::WORD_W-1:0]        lo_q;
   logic [mram_tx_pkg::WORD_W-1:0]        hi_q;
   logic [mram_tx_pkg::LINE_W-1:0]        pair;
   logic                                  load;
   logic                                  take_lo;
   logic                                  take_hi;
   logic                                  last_word;
   logic                                  beat_done;

   // Byte count to words, rounded up, at least one
   assign words_ceil = {2'b00, size_i[TRANS_SIZE-1:2]} +
                       {{(TRANS_SIZE-1){1'b0}}, |size_i[1:0]};
   assign words_init = (words_ceil == '0) ? TRANS_SIZE'(1) : words_ceil;

   assign last_word = (left_q == TRANS_SIZE'(1));
   assign beat_done = (state_q == ST_SEND) && gnt_i;

   always_comb
   begin
      state_d         = state_q;
      data_tx_ready_o = 1'b0;
      req_o           = 1'b0;
      take_lo         = 1'b0;
      take_hi         = 1'b0;
      load            = 1'b0;
      tx_done_o       = 1'b0;

      case (state_q)
         ST_GET_LO:
         begin
            data_tx_ready_o = 1'b1;
            if (data_tx_valid_i)
            begin
               take_lo = 1'b1;
               state_d = last_word ? ST_SEND : ST_GET_HI;
            end
         end

         ST_GET_HI:
         begin
            data_tx_ready_o = 1'b1;
            if (data_tx_valid_i)
            begin
               take_hi = 1'b1;
               state_d = ST_SEND;
            end
         end

         ST_SEND:
         begin
            req_o = 1'b1;
            if (gnt_i)
            begin
               if (left_q == '0)
               begin
                  tx_done_o = 1'b1;
                  state_d   = ST_IDLE;
               end
               else
               begin
                  data_tx_ready_o = 1'b1;   // Next pair starts in the grant cycle
                  if (data_tx_valid_i)
                  begin
                     take_lo = 1'b1;
                     state_d = last_word ? ST_SEND : ST_GET_HI;
                  end
                  else
                  begin
                     state_d = ST_GET_LO;
                  end
               end
            end
         end

         default:
         begin
            if (start_i)
            begin
               load    = 1'b1;
               state_d = ST_GET_LO;
            end
         end
      endcase
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state_q <= ST_IDLE;
         left_q  <= '0;
         addr_q  <= '0;
      end
      else
      begin
         state_q <= state_d;
         if (load)
         begin
            left_q <= words_init;
            addr_q <= addr_i;
         end
         else
         begin
            if (take_lo || take_hi)
               left_q <= left_q - 1'b1;
            if (beat_done)
               addr_q <= addr_q + 1'b1;
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (take_lo)
      begin
         lo_q <= data_tx_wdata_i;
         if (last_word)
            hi_q <= '0;                  // Odd tail pairs with zero
      end
      if (take_hi)
         hi_q <= data_tx_wdata_i;
   end

   assign pair    = {hi_q, lo_q};
   assign wdata_o = {{mram_tx_pkg::PAD_W{1'b0}}, ~pair};
   assign addr_o  = addr_q;
   assign eot_o   = (state_q == ST_SEND) && (left_q == '0);
   assign busy_o  = start_i || (state_q != ST_IDLE);

   a_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
      req_o && !gnt_i |=> req_o && $stable(addr_o) && $stable(wdata_o));

endmodule

`default_nettype wire

//--- hdl/mram_tx_pkg.sv
`default_nettype none

package mram_tx_pkg;

   localparam int WORD_W       = 32;
   localparam int LINE_W       = 64;          // Two memory words per beat
   localparam int BUS_W        = 78;
   localparam int PAD_W        = BUS_W - LINE_W;
   localparam int ADDR_W       = 16;
   localparam int ERASE_SIZE_W = 10;

   // One-hot command codes as seen on the register interface
   typedef enum logic [7:0]
   {
      MODE_NORMAL_TX  = 8'h02,
      MODE_ERASE_CHIP = 8'h04,
      MODE_ERASE_SECT = 8'h08,
      MODE_ERASE_WORD = 8'h10
   } mram_mode_t;

endpackage

`default_nettype wire

//--- hdl/mram_tx_top.sv
`timescale 1ns/1ps
`default_nettype none

module mram_tx_top
#(
   parameter int TRANS_SIZE = 16
)
(
   input  logic                                  clk,
   input  logic                                  rst_n,

   input  logic [mram_tx_pkg::WORD_W-1:0]        data_tx_wdata_i,
   input  logic                                  data_tx_valid_i,
   output logic                                  data_tx_ready_o,

   input  logic                                  push_cmd_req_i,
   output logic                                  push_cmd_gnt_o,
   input  logic [mram_tx_pkg::ADDR_W-1:0]        data_tx_addr_i,
   input  logic [TRANS_SIZE-1:0]                 data_tx_size_i,
   input  logic [mram_tx_pkg::ADDR_W-1:0]        erase_addr_i,
   input  logic [mram_tx_pkg::ERASE_SIZE_W-1:0]  erase_size_i,
   input  logic [7:0]                            mram_mode_i,

   output logic [mram_tx_pkg::BUS_W-1:0]         data_tx_wdata_o,
   output logic [mram_tx_pkg::ADDR_W-1:0]        data_tx_addr_o,
   output logic                                  data_tx_req_o,
   output logic                                  data_tx_eot_o,
   input  logic                                  data_tx_gnt_i,

   output logic                                  pending_o,
   output logic                                  tx_done_o,
   output logic                                  erase_pending_o,
   output logic                                  erase_done_o
);

   logic                                  pack_start;
   logic [mram_tx_pkg::ADDR_W-1:0]        cmd_tx_addr;
   logic [TRANS_SIZE-1:0]                 cmd_tx_size;
   logic                                  erase_start;
   mram_tx_pkg::mram_mode_t               cmd_erase_mode;
   logic [mram_tx_pkg::ADDR_W-1:0]        cmd_erase_addr;
   logic [mram_tx_pkg::ERASE_SIZE_W-1:0]  cmd_erase_size;

   logic                                  pack_busy;
   logic                                  pack_req;
   logic [mram_tx_pkg::ADDR_W-1:0]        pack_addr;
   logic [mram_tx_pkg::BUS_W-1:0]         pack_wdata;
   logic                                  pack_eot;
   logic                                  pack_gnt;

   logic                                  erase_busy;
   logic                                  erase_req;
   logic [mram_tx_pkg::ADDR_W-1:0]        erase_addr;
   logic [mram_tx_pkg::BUS_W-1:0]         erase_wdata;
   logic                                  erase_eot;
   logic                                  erase_gnt;

   mram_tx_ctrl #(.TRANS_SIZE(TRANS_SIZE)) u_ctrl
   (
      .clk, .rst_n,
      .push_cmd_req_i, .push_cmd_gnt_o, .mram_mode_i,
      .data_tx_addr_i, .data_tx_size_i, .erase_addr_i, .erase_size_i,
      .pending_o,
      .pack_start_o   (pack_start),
      .pack_addr_o    (cmd_tx_addr),
      .pack_size_o    (cmd_tx_size),
      .erase_start_o  (erase_start),
      .erase_mode_o   (cmd_erase_mode),
      .erase_addr_o   (cmd_erase_addr),
      .erase_size_o   (cmd_erase_size),
      .pack_busy_i    (pack_busy),
      .pack_req_i     (pack_req),
      .pack_addr_i    (pack_addr),
      .pack_wdata_i   (pack_wdata),
      .pack_eot_i     (pack_eot),
      .pack_gnt_o     (pack_gnt),
      .erase_busy_i   (erase_busy),
      .erase_req_i    (erase_req),
      .erase_addr_q_i (erase_addr),
      .erase_wdata_i  (erase_wdata),
      .erase_eot_i    (erase_eot),
      .erase_gnt_o    (erase_gnt),
      .data_tx_req_o, .data_tx_addr_o, .data_tx_wdata_o, .data_tx_eot_o,
      .data_tx_gnt_i
   );

   mram_tx_pack #(.TRANS_SIZE(TRANS_SIZE)) u_pack
   (
      .clk, .rst_n,
      .start_i (pack_start),
      .addr_i  (cmd_tx_addr),
      .size_i  (cmd_tx_size),
      .data_tx_wdata_i, .data_tx_valid_i, .data_tx_ready_o,
      .busy_o  (pack_busy),
      .req_o   (pack_req),
      .addr_o  (pack_addr),
      .wdata_o (pack_wdata),
      .eot_o   (pack_eot),
      .gnt_i   (pack_gnt),
      .tx_done_o
   );

   mram_tx_erase u_erase
   (
      .clk, .rst_n,
      .start_i (erase_start),
      .mode_i  (cmd_erase_mode),
      .addr_i  (cmd_erase_addr),
      .size_i  (cmd_erase_size),
      .busy_o  (erase_busy),
      .req_o   (erase_req),
      .addr_o  (erase_addr),
      .wdata_o (erase_wdata),
      .eot_o   (erase_eot),
      .gnt_i   (erase_gnt),
      .erase_pending_o, .erase_done_o
   );

endmodule

`default_nettype wire

//--- list.f
+incdir+testbench
hdl/mram_tx_pkg.sv
hdl/mram_tx_ctrl.sv
hdl/mram_tx_pack.sv
hdl/mram_tx_erase.sv
hdl/mram_tx_top.sv
testbench/tb_mram_tx.sv

//--- testbench/tb_mram_tx_table.svh
`ifndef TB_MRAM_TX_TABLE_SVH
`define TB_MRAM_TX_TABLE_SVH

// Columns: mode, tx address, byte count, erase address, erase count
localparam int N_ENTRIES = 10;

logic [7:0] tbl_mode [N_ENTRIES] = '{
   mram_tx_pkg::MODE_NORMAL_TX,  mram_tx_pkg::MODE_NORMAL_TX,  mram_tx_pkg::MODE_NORMAL_TX,
   mram_tx_pkg::MODE_NORMAL_TX,  mram_tx_pkg::MODE_ERASE_WORD, mram_tx_pkg::MODE_ERASE_SECT,
   mram_tx_pkg::MODE_ERASE_CHIP, 8'h40,                        mram_tx_pkg::MODE_NORMAL_TX,
   mram_tx_pkg::MODE_NORMAL_TX
};
logic [mram_tx_pkg::ADDR_W-1:0] tbl_addr [N_ENTRIES] = '{
   16'h0100, 16'h0200, 16'h0300, 16'hfffe, 16'h0555,
   16'h0666, 16'h0777, 16'h0888, 16'h0800, 16'h0a00
};
logic [TRANS_SIZE-1:0] tbl_bytes [N_ENTRIES] = '{
   16'd32, 16'd20, 16'd3, 16'd14, 16'd9, 16'd9, 16'd9, 16'd9, 16'd64, 16'd0
};
logic [mram_tx_pkg::ADDR_W-1:0] tbl_eaddr [N_ENTRIES] = '{
   16'h1111, 16'h2222, 16'h3333, 16'h4444, 16'h1234,
   16'h20ab, 16'h4000, 16'h5000, 16'h6000, 16'h7000
};
logic [mram_tx_pkg::ERASE_SIZE_W-1:0] tbl_ecount [N_ENTRIES] = '{
   10'd3, 10'd3, 10'd3, 10'd3, 10'd5, 10'd3, 10'd7, 10'd2, 10'd1, 10'd1
};

`endif

//--- testbench/tb_mram_tx.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mram_tx;

   localparam int TRANS_SIZE = 16;
   localparam int DRV_DLY    = 5;                // After the rising edge

   logic                                  clk;
   logic                                  rst_n;
   logic [mram_tx_pkg::WORD_W-1:0]        data_tx_wdata_i;
   logic                                  data_tx_valid_i;
   logic                                  data_tx_ready_o;
   logic                                  push_cmd_req_i;
   logic                                  push_cmd_gnt_o;
   logic [mram_tx_pkg::ADDR_W-1:0]        data_tx_addr_i;
   logic [TRANS_SIZE-1:0]                 data_tx_size_i;
   logic [mram_tx_pkg::ADDR_W-1:0]        erase_addr_i;
   logic [mram_tx_pkg::ERASE_SIZE_W-1:0]  erase_size_i;
   logic [7:0]                            mram_mode_i;
   logic [mram_tx_pkg::BUS_W-1:0]         data_tx_wdata_o;
   logic [mram_tx_pkg::ADDR_W-1:0]        data_tx_addr_o;
   logic                                  data_tx_req_o;
   logic                                  data_tx_eot_o;
   logic                                  data_tx_gnt_i;
   logic                                  pending_o;
   logic                                  tx_done_o;
   logic                                  erase_pending_o;
   logic                                  erase_done_o;

   logic [mram_tx_pkg::ADDR_W-1:0]        exp_addr [$];
   logic [mram_tx_pkg::BUS_W-1:0]         exp_data [$];
   logic [mram_tx_pkg::WORD_W-1:0]        words [$];

   integer seed;
   int     errors;
   int     failed;
   int     cycles;
   int     cycle_limit;

   `include "tb_mram_tx_table.svh"

   mram_tx_top #(.TRANS_SIZE(TRANS_SIZE)) UUT
   (
      .clk, .rst_n,
      .data_tx_wdata_i, .data_tx_valid_i, .data_tx_ready_o,
      .push_cmd_req_i, .push_cmd_gnt_o, .data_tx_addr_i, .data_tx_size_i,
      .erase_addr_i, .erase_size_i, .mram_mode_i,
      .data_tx_wdata_o, .data_tx_addr_o, .data_tx_req_o, .data_tx_eot_o, .data_tx_gnt_i,
      .pending_o, .tx_done_o, .erase_pending_o, .erase_done_o
   );

   always #50 clk = ~clk;

   always @(posedge clk)
   begin
      cycles++;
      if (cycles > cycle_limit)
      begin
         $display("Timeout after %0d cycles, the DUT stopped making progress", cycles);
         $display("TEST RESULT: FAIL");
         $finish;
      end
   end

   task automatic check_value(input string name, input logic [mram_tx_pkg::BUS_W-1:0] got,
                              input logic [mram_tx_pkg::BUS_W-1:0] exp);
      if (got !== exp)
      begin
         $display("ERROR: %s is %h, expected %h at %0t", name, got, exp, $time);
         errors++;
      end
   endtask

   function automatic int expected_beats(input int idx);
      int n_words;
      n_words = (tbl_bytes[idx] + 3) / 4;
      if (n_words == 0)
         n_words = 1;
      case (tbl_mode[idx])
         mram_tx_pkg::MODE_NORMAL_TX:  return (n_words + 1) / 2;
         mram_tx_pkg::MODE_ERASE_WORD: return tbl_ecount[idx] + 1;
         mram_tx_pkg::MODE_ERASE_SECT: return tbl_ecount[idx] + 1;
         mram_tx_pkg::MODE_ERASE_CHIP: return 1;
         default:                      return 0;
      endcase
   endfunction

   // Reference model of the beats one command produces
   task automatic build_expected(input int idx);
      int                             n_words;
      int                             i;
      logic [mram_tx_pkg::WORD_W-1:0] hi;
      logic [mram_tx_pkg::ADDR_W-1:0] a;
      exp_addr.delete();
      exp_data.delete();
      words.delete();
      a = tbl_eaddr[idx];
      if (tbl_mode[idx] == mram_tx_pkg::MODE_NORMAL_TX)
      begin
         n_words = (tbl_bytes[idx] + 3) / 4;
         if (n_words == 0)
            n_words = 1;
         for (i = 0; i < n_words; i++)
            words.push_back($random(seed));
         for (i = 0; i < n_words; i += 2)
         begin
            hi = (i + 1 < n_words) ? words[i + 1] : '0;   // Odd tail
            exp_data.push_back({{mram_tx_pkg::PAD_W{1'b0}}, ~{hi, words[i]}});
            exp_addr.push_back(16'(tbl_addr[idx] + i / 2));
         end
      end
      else
      begin
         for (i = 0; i < expected_beats(idx); i++)
         begin
            exp_data.push_back({mram_tx_pkg::BUS_W{1'b1}});
            exp_addr.push_back(a);
            if (tbl_mode[idx] == mram_tx_pkg::MODE_ERASE_WORD)
               a = a + 1'b1;
            else
               a = {a[15:8] + 8'd1, 8'h00};
         end
      end
   endtask

   task automatic apply_entry(input int idx);
      int                             n_beats;
      int                             beats_seen;
      int                             word_ptr;
      int                             errs_before;
      logic                           is_tx;
      logic                           is_erase;
      logic                           accepted;
      logic                           hold_q;
      logic                           last_q;
      logic                           running;
      logic [mram_tx_pkg::ADDR_W-1:0] addr_prev;
      logic [mram_tx_pkg::BUS_W-1:0]  data_prev;
      errs_before = errors;
      build_expected(idx);
      n_beats    = exp_addr.size();
      beats_seen = 0;
      word_ptr   = 0;
      hold_q     = 1'b0;
      last_q     = 1'b0;
      addr_prev  = '0;
      data_prev  = '0;
      is_tx      = (tbl_mode[idx] == mram_tx_pkg::MODE_NORMAL_TX);
      is_erase   = (n_beats > 0) && !is_tx;

      push_cmd_req_i = 1'b1;
      mram_mode_i    = tbl_mode[idx];
      data_tx_addr_i = tbl_addr[idx];
      data_tx_size_i = tbl_bytes[idx];
      erase_addr_i   = tbl_eaddr[idx];
      erase_size_i   = tbl_ecount[idx];
      @(posedge clk);
      while (!push_cmd_gnt_o)
         @(posedge clk);
      #DRV_DLY;
      push_cmd_req_i = 1'b0;

      running = 1'b1;
      while (running)
      begin
         @(posedge clk);
         accepted = data_tx_valid_i && data_tx_ready_o;
         if (accepted)
            word_ptr++;
         if (hold_q)
         begin
            check_value("data_tx_req_o", data_tx_req_o, 1'b1);
            check_value("data_tx_addr_o", data_tx_addr_o, addr_prev);
            check_value("data_tx_wdata_o", data_tx_wdata_o, data_prev);
         end
         if (is_tx && data_tx_req_o && !data_tx_gnt_i)
            check_value("data_tx_ready_o", data_tx_ready_o, 1'b0);
         check_value("tx_done_o", tx_done_o,
                     is_tx && data_tx_req_o && data_tx_gnt_i && (beats_seen == n_beats - 1));
         check_value("erase_done_o", erase_done_o, last_q);
         check_value("erase_pending_o", erase_pending_o, is_erase && data_tx_req_o);
         last_q = 1'b0;
         if (data_tx_req_o && beats_seen >= n_beats)
         begin
            $display("Unexpected request at address %h, no beat left to expect", data_tx_addr_o);
            errors++;
         end
         else if (data_tx_req_o && data_tx_gnt_i)
         begin
            check_value("data_tx_addr_o", data_tx_addr_o, exp_addr[beats_seen]);
            check_value("data_tx_wdata_o", data_tx_wdata_o, exp_data[beats_seen]);
            check_value("data_tx_eot_o", data_tx_eot_o, beats_seen == n_beats - 1);
            last_q = is_erase && (beats_seen == n_beats - 1);
            beats_seen++;
         end
         hold_q    = data_tx_req_o && !data_tx_gnt_i;
         addr_prev = data_tx_addr_o;
         data_prev = data_tx_wdata_o;
         running   = (beats_seen < n_beats) || pending_o || last_q;
         if (running)
         begin
            #DRV_DLY;
            if (!data_tx_valid_i || accepted)            // A valid word waits for ready
            begin
               data_tx_valid_i = (word_ptr < words.size()) && (($random(seed) & 3) != 0);
               if (data_tx_valid_i)
                  data_tx_wdata_i = words[word_ptr];
               else
                  data_tx_wdata_i = '0;
            end
            data_tx_gnt_i = data_tx_req_o && (($random(seed) & 3) != 0);
         end
      end
      #DRV_DLY;
      data_tx_valid_i = 1'b0;
      data_tx_gnt_i   = 1'b0;
      check_value("words accepted", word_ptr, words.size());
      if (errors != errs_before)
         failed++;
      $display("Test %0d, mode %h, %0d beats: %0d errors", idx, tbl_mode[idx], n_beats,
               errors - errs_before);
   endtask

   initial
   begin
      int i;
      clk             = 1'b0;
      rst_n           = 1'b0;
      data_tx_wdata_i = '0;
      data_tx_valid_i = 1'b0;
      push_cmd_req_i  = 1'b0;
      data_tx_addr_i  = '0;
      data_tx_size_i  = '0;
      erase_addr_i    = '0;
      erase_size_i    = '0;
      mram_mode_i     = '0;
      data_tx_gnt_i   = 1'b0;
      seed            = 32'hd10fc23a;
      errors          = 0;
      failed          = 0;
      cycles          = 0;
      cycle_limit     = 0;
      for (i = 0; i < N_ENTRIES; i++)
         cycle_limit += 20 * expected_beats(i) + 50;

      repeat (3) @(posedge clk);
      #DRV_DLY;
      rst_n = 1'b1;
      @(posedge clk);
      check_value("data_tx_req_o", data_tx_req_o, 1'b0);
      check_value("data_tx_ready_o", data_tx_ready_o, 1'b0);
      check_value("push_cmd_gnt_o", push_cmd_gnt_o, 1'b0);
      check_value("data_tx_eot_o", data_tx_eot_o, 1'b0);
      check_value("tx_done_o", tx_done_o, 1'b0);
      check_value("erase_done_o", erase_done_o, 1'b0);
      check_value("erase_pending_o", erase_pending_o, 1'b0);
      check_value("pending_o", pending_o, 1'b0);
      if (errors != 0)
         failed++;
      $display("Test reset values: %0d errors", errors);
      #DRV_DLY;

      for (i = 0; i < N_ENTRIES; i++)
         apply_entry(i);

      $display("Tests run: %0d, failed: %0d, errors: %0d", N_ENTRIES + 1, failed, errors);
      if (errors == 0)
         $display("TEST RESULT: PASS");
      else
         $display("TEST RESULT: FAIL");
      $finish;
   end

endmodule

`default_nettype wire
